//--- vlog.f
null_src_sink_pkg.sv
stream_line_counter.sv
loop_buffer.sv
null_source.sv
null_src_sink_regs.sv
null_src_sink_core.sv
tb_null_src_sink.sv

//--- tb_null_src_sink.sv
module tb_null_src_sink;

  // Test sizes, also used for the timeout
  localparam int src_pkts_total  = 12;
  localparam int max_lpp         = 3;
  localparam int max_throttle    = 2;
  localparam int snk_pkts_total  = 10;
  localparam int snk_max_len     = 8;
  localparam int loop_pyld_beats = 30;
  localparam int loop_ctxt_beats = 12;
  localparam int reg_ops         = 150;
  localparam int timeout_cycles  = 4 * (src_pkts_total * (max_lpp + max_throttle + 4)
    + snk_pkts_total * snk_max_len * 4 + loop_pyld_beats * 3 + reg_ops * 2) + 500;

  logic                              rfnoc_chdr_clk = 1'b0;
  logic                              rfnoc_chdr_rst;
  null_src_sink_pkg::pyld_beat_t     snk_pyld;
  logic                              snk_pyld_valid;
  logic                              snk_pyld_ready;
  logic                              snk_ctxt_ready;
  null_src_sink_pkg::pyld_beat_t     loop_in_pyld;
  logic                              loop_in_pyld_valid;
  logic                              loop_in_pyld_ready;
  null_src_sink_pkg::ctxt_beat_t     loop_in_ctxt;
  logic                              loop_in_ctxt_valid;
  logic                              loop_in_ctxt_ready;
  null_src_sink_pkg::pyld_beat_t     loop_out_pyld;
  logic                              loop_out_pyld_valid;
  logic                              loop_out_pyld_ready;
  null_src_sink_pkg::ctxt_beat_t     loop_out_ctxt;
  logic                              loop_out_ctxt_valid;
  logic                              loop_out_ctxt_ready;
  null_src_sink_pkg::pyld_beat_t     src_pyld;
  logic                              src_pyld_valid;
  logic                              src_pyld_ready;
  null_src_sink_pkg::ctxt_beat_t     src_ctxt;
  logic                              src_ctxt_valid;
  logic                              src_ctxt_ready;
  null_src_sink_pkg::ctrlport_req_t  ctrlport_req;
  null_src_sink_pkg::ctrlport_resp_t ctrlport_resp;

  // Model state
  logic [31:0] lfsr = 32'h9734dc96;
  logic        model_en;
  logic [11:0] model_lpp;
  logic [15:0] model_bpp;
  logic [9:0]  model_throttle;
  logic [63:0] snk_lines, snk_pkts, src_lines, src_pkts, loop_lines, loop_pkts;
  logic        mid_pkt;
  logic        gap_check;
  logic        src_stall;
  int          line_in_pkt;
  int          idle_cnt;
  int          cycles;
  null_src_sink_pkg::pyld_beat_t pyld_q[$];
  null_src_sink_pkg::ctxt_beat_t ctxt_q[$];

  null_src_sink_core dut (.*);

  always #20 rfnoc_chdr_clk = ~rfnoc_chdr_clk;

  // --------------------------------------------------------------------------
  // Random bits, reference model and compare tasks
  // --------------------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic null_src_sink_pkg::ctxt_beat_t exp_header(input logic [15:0] seq,
                                                               input logic [15:0] len);
    null_src_sink_pkg::ctxt_beat_t b;
    b.data = '0;
    b.data[55:53] = null_src_sink_pkg::chdr_pkt_type_data;
    b.data[47:32] = seq;
    b.data[31:16] = len;
    b.user = null_src_sink_pkg::context_field_hdr;
    b.last = 1'b1;
    return b;
  endfunction

  function automatic null_src_sink_pkg::pyld_beat_t exp_line(input logic [15:0] cnt,
                                                             input logic last);
    null_src_sink_pkg::pyld_beat_t b;
    for (int i = 0; i < null_src_sink_pkg::nipc; i++) begin
      b.data[i*null_src_sink_pkg::item_w +: null_src_sink_pkg::item_w] = {~cnt, cnt};
    end
    b.keep = '1;
    b.last = last;
    return b;
  endfunction

  function automatic logic [31:0] exp_status(input logic [1:0] st, input logic en);
    return {8'(null_src_sink_pkg::nipc), 8'(null_src_sink_pkg::item_w), st, 12'h0, en, 1'b0};
  endfunction

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic value_error(input string msg);
    $display("** Error at time %0t: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_pyld(input null_src_sink_pkg::pyld_beat_t got,
                            input null_src_sink_pkg::pyld_beat_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_ctxt(input null_src_sink_pkg::ctxt_beat_t got,
                            input null_src_sink_pkg::ctxt_beat_t exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) value_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  // --------------------------------------------------------------------------
  // Register port
  // --------------------------------------------------------------------------
  task automatic reg_write(input logic [19:0] addr, input logic [31:0] data);
    @(negedge rfnoc_chdr_clk);
    if (ctrlport_resp.ack) report_failure("Acknowledge seen without a request");
    ctrlport_req = '{wr: 1'b1, rd: 1'b0, addr: addr, data: data};
    @(negedge rfnoc_chdr_clk);
    ctrlport_req.wr = 1'b0;
    if (!ctrlport_resp.ack) report_failure("Register write got no acknowledge");
    case (addr)
      null_src_sink_pkg::reg_ctrl_status: begin
        model_en = data[1];
        if (!data[1]) gap_check = 1'b0;
        if (data[0]) begin
          {snk_lines, snk_pkts, src_lines, src_pkts, loop_lines, loop_pkts} = '0;
        end
      end
      null_src_sink_pkg::reg_src_lines_per_pkt: model_lpp = data[11:0];
      null_src_sink_pkg::reg_src_bytes_per_pkt: model_bpp = data[15:0];
      null_src_sink_pkg::reg_src_throttle_cyc:  model_throttle = data[9:0];
      default: ;
    endcase
  endtask

  task automatic reg_read(input logic [19:0] addr, input logic [31:0] exp, input string what);
    @(negedge rfnoc_chdr_clk);
    if (ctrlport_resp.ack) report_failure("Acknowledge seen without a request");
    ctrlport_req = '{wr: 1'b0, rd: 1'b1, addr: addr, data: 32'h0};
    @(negedge rfnoc_chdr_clk);
    ctrlport_req.rd = 1'b0;
    if (!ctrlport_resp.ack) report_failure("Register read got no acknowledge");
    check_word(ctrlport_resp.data, exp, what);
  endtask

  task automatic check_counter(input logic [19:0] addr, input logic [63:0] exp,
                               input string what);
    reg_read(addr, exp[31:0], {what, " lo"});
    reg_read(addr + 20'h4, exp[63:32], {what, " hi"});
  endtask

  task automatic check_all_counters();
    check_counter(null_src_sink_pkg::reg_snk_line_cnt_lo, snk_lines, "sink lines");
    check_counter(null_src_sink_pkg::reg_snk_pkt_cnt_lo, snk_pkts, "sink packets");
    check_counter(null_src_sink_pkg::reg_src_line_cnt_lo, src_lines, "source lines");
    check_counter(null_src_sink_pkg::reg_src_pkt_cnt_lo, src_pkts, "source packets");
    check_counter(null_src_sink_pkg::reg_loop_line_cnt_lo, loop_lines, "loop lines");
    check_counter(null_src_sink_pkg::reg_loop_pkt_cnt_lo, loop_pkts, "loop packets");
  endtask

  // --------------------------------------------------------------------------
  // Stream drivers
  // --------------------------------------------------------------------------
  task automatic run_source(input int n, input logic [11:0] lpp, input logic [9:0] thr);
    logic [63:0] target;
    reg_write(null_src_sink_pkg::reg_src_lines_per_pkt, 32'(lpp));
    reg_write(null_src_sink_pkg::reg_src_throttle_cyc, 32'(thr));
    target = src_pkts + 64'(n);
    reg_write(null_src_sink_pkg::reg_ctrl_status, 32'h2);
    while (src_pkts < target) @(negedge rfnoc_chdr_clk);
    reg_write(null_src_sink_pkg::reg_ctrl_status, 32'h0);
    // Current packet finishes, then nothing more
    while (mid_pkt) @(negedge rfnoc_chdr_clk);
    repeat (int'(thr) + 2 * int'(lpp) + 6) @(negedge rfnoc_chdr_clk);
    reg_read(null_src_sink_pkg::reg_ctrl_status, exp_status(2'd0, 1'b0), "idle status");
  endtask

  task automatic send_sink(input int n_pkts);
    int len;
    for (int p = 0; p < n_pkts; p++) begin
      len = 1 + int'(rand_bits(3));
      for (int l = 0; l < len; l++) begin
        repeat (int'(rand_bits(2))) @(negedge rfnoc_chdr_clk);
        snk_pyld.data  = {rand_bits(32), rand_bits(32)};
        snk_pyld.keep  = rand_bits(2);
        snk_pyld.last  = (l == len - 1);
        snk_pyld_valid = 1'b1;
        @(posedge rfnoc_chdr_clk);
        if (!snk_pyld_ready || !snk_ctxt_ready) report_failure("Sink did not accept a line");
        @(negedge rfnoc_chdr_clk);
        snk_pyld_valid = 1'b0;
        snk_lines++;
      end
      snk_pkts++;
    end
  endtask

  task automatic send_loop_pyld(input int n);
    for (int i = 0; i < n; i++) begin
      repeat (int'(rand_bits(1))) @(negedge rfnoc_chdr_clk);
      loop_in_pyld.data  = {rand_bits(32), rand_bits(32)};
      loop_in_pyld.keep  = rand_bits(2);
      loop_in_pyld.last  = rand_bits(1);
      loop_in_pyld_valid = 1'b1;
      pyld_q.push_back(loop_in_pyld);
      do @(posedge rfnoc_chdr_clk); while (!loop_in_pyld_ready);
      @(negedge rfnoc_chdr_clk);
      loop_in_pyld_valid = 1'b0;
      loop_lines++;
      if (loop_in_pyld.last) loop_pkts++;
    end
  endtask

  task automatic send_loop_ctxt(input int n);
    for (int i = 0; i < n; i++) begin
      repeat (int'(rand_bits(1))) @(negedge rfnoc_chdr_clk);
      loop_in_ctxt.data  = {rand_bits(32), rand_bits(32)};
      loop_in_ctxt.user  = rand_bits(4);
      loop_in_ctxt.last  = rand_bits(1);
      loop_in_ctxt_valid = 1'b1;
      ctxt_q.push_back(loop_in_ctxt);
      do @(posedge rfnoc_chdr_clk); while (!loop_in_ctxt_ready);
      @(negedge rfnoc_chdr_clk);
      loop_in_ctxt_valid = 1'b0;
    end
  endtask

  // Random back-pressure
  always @(negedge rfnoc_chdr_clk) begin
    if (!rfnoc_chdr_rst) begin
      src_pyld_ready      = rand_bits(1) && !src_stall;
      src_ctxt_ready      = rand_bits(1);
      loop_out_pyld_ready = rand_bits(1);
      loop_out_ctxt_ready = rand_bits(1);
    end
  end

  // --------------------------------------------------------------------------
  // Compare process
  // --------------------------------------------------------------------------
  always @(posedge rfnoc_chdr_clk) begin
    if (!rfnoc_chdr_rst) begin
      if (gap_check && src_ctxt_valid) begin
        check_word(32'(idle_cnt), (model_throttle == 0) ? 32'd0 : 32'(model_throttle) + 1,
                   "idle gap between packets");
        gap_check = 1'b0;
      end
      if (src_ctxt_valid && src_ctxt_ready) begin
        if (!model_en) report_failure("Source sent a header while disabled");
        if (mid_pkt) report_failure("Source sent a header inside a packet");
        check_ctxt(src_ctxt, exp_header(src_pkts[15:0], model_bpp), "source header");
        mid_pkt     = 1'b1;
        line_in_pkt = 0;
      end
      if (src_pyld_valid && src_pyld_ready) begin
        if (!mid_pkt) report_failure("Source sent a line without a header");
        check_pyld(src_pyld, exp_line(src_lines[15:0], line_in_pkt == int'(model_lpp)),
                   "source line");
        src_lines++;
        line_in_pkt++;
        if (src_pyld.last) begin
          mid_pkt   = 1'b0;
          gap_check = model_en;
          idle_cnt  = 0;
          src_pkts++;
        end
      end else if (!src_ctxt_valid) begin
        idle_cnt++;
      end
      if (loop_out_pyld_valid && loop_out_pyld_ready) begin
        if (pyld_q.size() == 0) report_failure("Loop payload beat came out with none sent");
        else check_pyld(loop_out_pyld, pyld_q.pop_front(), "loop payload");
      end
      if (loop_out_ctxt_valid && loop_out_ctxt_ready) begin
        if (ctxt_q.size() == 0) report_failure("Loop context beat came out with none sent");
        else check_ctxt(loop_out_ctxt, ctxt_q.pop_front(), "loop context");
      end
    end
  end

  always @(posedge rfnoc_chdr_clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, the test did not finish", cycles);
      abort_run();
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    rfnoc_chdr_rst = 1'b1;
    {snk_pyld, loop_in_pyld, loop_in_ctxt} = '0;
    {snk_pyld_valid, loop_in_pyld_valid, loop_in_ctxt_valid} = '0;
    {src_pyld_ready, src_ctxt_ready, loop_out_pyld_ready, loop_out_ctxt_ready} = '0;
    ctrlport_req = '0;
    {model_en, model_lpp, model_bpp, model_throttle} = '0;
    {snk_lines, snk_pkts, src_lines, src_pkts, loop_lines, loop_pkts} = '0;
    {mid_pkt, gap_check, src_stall} = '0;
    {line_in_pkt, idle_cnt, cycles} = '0;
    repeat (16) @(posedge rfnoc_chdr_clk);
    @(negedge rfnoc_chdr_clk);
    rfnoc_chdr_rst = 1'b0;

    // Registers after reset
    check_all_counters();
    reg_read(null_src_sink_pkg::reg_ctrl_status, exp_status(2'd0, 1'b0), "reset status");
    reg_write(null_src_sink_pkg::reg_src_lines_per_pkt, 32'hFFFF_F003);
    reg_write(null_src_sink_pkg::reg_src_bytes_per_pkt, 32'hABCD_0120);
    reg_write(null_src_sink_pkg::reg_src_throttle_cyc, 32'hFFFF_FC02);
    reg_read(null_src_sink_pkg::reg_src_lines_per_pkt, 32'h0000_0003, "lpp readback");
    reg_read(null_src_sink_pkg::reg_src_bytes_per_pkt, 32'h0000_0120, "bpp readback");
    reg_read(null_src_sink_pkg::reg_src_throttle_cyc, 32'h0000_0002, "throttle readback");
    reg_write(null_src_sink_pkg::reg_src_bytes_per_pkt, 32'h0000_0120);
    check_word(ctrlport_resp.data, 32'h0000_0002, "read data held over a write");
    reg_read(20'h00040, 32'h0, "unmapped read");

    // Status with the source stalled inside a packet
    src_stall = 1'b1;
    reg_write(null_src_sink_pkg::reg_ctrl_status, 32'h2);
    while (!mid_pkt) @(negedge rfnoc_chdr_clk);
    reg_read(null_src_sink_pkg::reg_ctrl_status, exp_status(2'd1, 1'b1), "busy status");
    reg_write(null_src_sink_pkg::reg_ctrl_status, 32'h0);
    src_stall = 1'b0;
    while (mid_pkt) @(negedge rfnoc_chdr_clk);

    // Source under back-pressure
    run_source(5, 12'd3, 10'd2);
    reg_write(null_src_sink_pkg::reg_src_bytes_per_pkt, 32'h0000_0040);
    run_source(4, 12'd0, 10'd0);
    check_all_counters();

    // Sink and loopback
    send_sink(snk_pkts_total);
    fork
      send_loop_pyld(loop_pyld_beats);
      send_loop_ctxt(loop_ctxt_beats);
    join
    while (pyld_q.size() != 0 || ctxt_q.size() != 0) @(negedge rfnoc_chdr_clk);
    check_all_counters();

    // Clear, then the sequence restarts from zero
    reg_write(null_src_sink_pkg::reg_ctrl_status, 32'h1);
    check_all_counters();
    run_source(2, 12'd1, 10'd1);
    check_all_counters();

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- null_src_sink_core.sv
module null_src_sink_core (
  input  logic                              rfnoc_chdr_clk,
  input  logic                              rfnoc_chdr_rst,
  // Sink
  input  null_src_sink_pkg::pyld_beat_t     snk_pyld,
  input  logic                              snk_pyld_valid,
  output logic                              snk_pyld_ready,
  output logic                              snk_ctxt_ready,
  // Loop input
  input  null_src_sink_pkg::pyld_beat_t     loop_in_pyld,
  input  logic                              loop_in_pyld_valid,
  output logic                              loop_in_pyld_ready,
  input  null_src_sink_pkg::ctxt_beat_t     loop_in_ctxt,
  input  logic                              loop_in_ctxt_valid,
  output logic                              loop_in_ctxt_ready,
  // Loop output
  output null_src_sink_pkg::pyld_beat_t     loop_out_pyld,
  output logic                              loop_out_pyld_valid,
  input  logic                              loop_out_pyld_ready,
  output null_src_sink_pkg::ctxt_beat_t     loop_out_ctxt,
  output logic                              loop_out_ctxt_valid,
  input  logic                              loop_out_ctxt_ready,
  // Source
  output null_src_sink_pkg::pyld_beat_t     src_pyld,
  output logic                              src_pyld_valid,
  input  logic                              src_pyld_ready,
  output null_src_sink_pkg::ctxt_beat_t     src_ctxt,
  output logic                              src_ctxt_valid,
  input  logic                              src_ctxt_ready,
  // Register port
  input  null_src_sink_pkg::ctrlport_req_t  ctrlport_req,
  output null_src_sink_pkg::ctrlport_resp_t ctrlport_resp
);

  null_src_sink_pkg::src_cfg_t         src_cfg;
  logic                                clear_cnts;
  logic [1:0]                          src_state;
  logic [null_src_sink_pkg::cnt_w-1:0] snk_line_cnt;
  logic [null_src_sink_pkg::cnt_w-1:0] snk_pkt_cnt;
  logic [null_src_sink_pkg::cnt_w-1:0] src_line_cnt;
  logic [null_src_sink_pkg::cnt_w-1:0] src_pkt_cnt;
  logic [null_src_sink_pkg::cnt_w-1:0] loop_line_cnt;
  logic [null_src_sink_pkg::cnt_w-1:0] loop_pkt_cnt;

  // ------------------------------------------------------------------------
  // Null sink, everything is dropped
  // ------------------------------------------------------------------------
  assign snk_pyld_ready = 1'b1;
  assign snk_ctxt_ready = 1'b1;

  stream_line_counter u_snk_cnt (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .clear          (clear_cnts),
    .valid          (snk_pyld_valid),
    .ready          (snk_pyld_ready),
    .last           (snk_pyld.last),
    .line_cnt       (snk_line_cnt),
    .pkt_cnt        (snk_pkt_cnt)
  );

  // ------------------------------------------------------------------------
  // Loopback
  // ------------------------------------------------------------------------
  loop_buffer #(.beat_t(null_src_sink_pkg::pyld_beat_t)) u_loop_pyld (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .in_beat        (loop_in_pyld),
    .in_valid       (loop_in_pyld_valid),
    .in_ready       (loop_in_pyld_ready),
    .out_beat       (loop_out_pyld),
    .out_valid      (loop_out_pyld_valid),
    .out_ready      (loop_out_pyld_ready)
  );

  loop_buffer #(.beat_t(null_src_sink_pkg::ctxt_beat_t)) u_loop_ctxt (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .in_beat        (loop_in_ctxt),
    .in_valid       (loop_in_ctxt_valid),
    .in_ready       (loop_in_ctxt_ready),
    .out_beat       (loop_out_ctxt),
    .out_valid      (loop_out_ctxt_valid),
    .out_ready      (loop_out_ctxt_ready)
  );

  stream_line_counter u_loop_cnt (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .clear          (clear_cnts),
    .valid          (loop_out_pyld_valid),
    .ready          (loop_out_pyld_ready),
    .last           (loop_out_pyld.last),
    .line_cnt       (loop_line_cnt),
    .pkt_cnt        (loop_pkt_cnt)
  );

  // ------------------------------------------------------------------------
  // Null source
  // ------------------------------------------------------------------------
  null_source u_src (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .cfg            (src_cfg),
    .pkt_cnt        (src_pkt_cnt[15:0]),
    .line_cnt       (src_line_cnt[15:0]),
    .pyld           (src_pyld),
    .pyld_valid     (src_pyld_valid),
    .pyld_ready     (src_pyld_ready),
    .ctxt           (src_ctxt),
    .ctxt_valid     (src_ctxt_valid),
    .ctxt_ready     (src_ctxt_ready),
    .state          (src_state)
  );

  stream_line_counter u_src_cnt (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .clear          (clear_cnts),
    .valid          (src_pyld_valid),
    .ready          (src_pyld_ready),
    .last           (src_pyld.last),
    .line_cnt       (src_line_cnt),
    .pkt_cnt        (src_pkt_cnt)
  );

  null_src_sink_regs u_regs (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .req            (ctrlport_req),
    .resp           (ctrlport_resp),
    .src_cfg        (src_cfg),
    .clear_cnts     (clear_cnts),
    .src_state      (src_state),
    .snk_line_cnt   (snk_line_cnt),
    .snk_pkt_cnt    (snk_pkt_cnt),
    .src_line_cnt   (src_line_cnt),
    .src_pkt_cnt    (src_pkt_cnt),
    .loop_line_cnt  (loop_line_cnt),
    .loop_pkt_cnt   (loop_pkt_cnt)
  );

endmodule

//--- null_src_sink_regs.sv
module null_src_sink_regs (
  input  logic                                rfnoc_chdr_clk,
  input  logic                                rfnoc_chdr_rst,
  input  null_src_sink_pkg::ctrlport_req_t    req,
  output null_src_sink_pkg::ctrlport_resp_t   resp,
  output null_src_sink_pkg::src_cfg_t         src_cfg,
  output logic                                clear_cnts,
  input  logic [1:0]                          src_state,
  input  logic [null_src_sink_pkg::cnt_w-1:0] snk_line_cnt,
  input  logic [null_src_sink_pkg::cnt_w-1:0] snk_pkt_cnt,
  input  logic [null_src_sink_pkg::cnt_w-1:0] src_line_cnt,
  input  logic [null_src_sink_pkg::cnt_w-1:0] src_pkt_cnt,
  input  logic [null_src_sink_pkg::cnt_w-1:0] loop_line_cnt,
  input  logic [null_src_sink_pkg::cnt_w-1:0] loop_pkt_cnt
);

  logic        resp_ack;
  logic [31:0] resp_data;
  logic [31:0] rd_value;

  assign resp.ack  = resp_ack;
  assign resp.data = resp_data;

  // ------------------------------------------------------------------------
  // Writes
  // ------------------------------------------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      resp_ack   <= 1'b0;
      clear_cnts <= 1'b0;
      src_cfg    <= '0;
    end else begin
      resp_ack <= req.wr || req.rd;
      // Clear is a single-cycle pulse
      clear_cnts <= 1'b0;
      if (req.wr) begin
        case (req.addr)
          null_src_sink_pkg::reg_ctrl_status: begin
            src_cfg.en <= req.data[1];
            clear_cnts <= req.data[0];
          end
          null_src_sink_pkg::reg_src_lines_per_pkt: begin
            src_cfg.lpp <= req.data[11:0];
          end
          null_src_sink_pkg::reg_src_bytes_per_pkt: begin
            src_cfg.bpp <= req.data[15:0];
          end
          null_src_sink_pkg::reg_src_throttle_cyc: begin
            src_cfg.throttle <= req.data[9:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // ------------------------------------------------------------------------
  // Reads
  // ------------------------------------------------------------------------
  always_comb begin
    case (req.addr)
      null_src_sink_pkg::reg_ctrl_status:
        rd_value = {8'(null_src_sink_pkg::nipc), 8'(null_src_sink_pkg::item_w),
                    src_state, 12'h0, src_cfg.en, clear_cnts};
      null_src_sink_pkg::reg_src_lines_per_pkt: rd_value = {20'h0, src_cfg.lpp};
      null_src_sink_pkg::reg_src_bytes_per_pkt: rd_value = {16'h0, src_cfg.bpp};
      null_src_sink_pkg::reg_src_throttle_cyc:  rd_value = {22'h0, src_cfg.throttle};
      null_src_sink_pkg::reg_snk_line_cnt_lo:   rd_value = snk_line_cnt[31:0];
      null_src_sink_pkg::reg_snk_line_cnt_hi:   rd_value = snk_line_cnt[63:32];
      null_src_sink_pkg::reg_snk_pkt_cnt_lo:    rd_value = snk_pkt_cnt[31:0];
      null_src_sink_pkg::reg_snk_pkt_cnt_hi:    rd_value = snk_pkt_cnt[63:32];
      null_src_sink_pkg::reg_src_line_cnt_lo:   rd_value = src_line_cnt[31:0];
      null_src_sink_pkg::reg_src_line_cnt_hi:   rd_value = src_line_cnt[63:32];
      null_src_sink_pkg::reg_src_pkt_cnt_lo:    rd_value = src_pkt_cnt[31:0];
      null_src_sink_pkg::reg_src_pkt_cnt_hi:    rd_value = src_pkt_cnt[63:32];
      null_src_sink_pkg::reg_loop_line_cnt_lo:  rd_value = loop_line_cnt[31:0];
      null_src_sink_pkg::reg_loop_line_cnt_hi:  rd_value = loop_line_cnt[63:32];
      null_src_sink_pkg::reg_loop_pkt_cnt_lo:   rd_value = loop_pkt_cnt[31:0];
      null_src_sink_pkg::reg_loop_pkt_cnt_hi:   rd_value = loop_pkt_cnt[63:32];
      default:                                  rd_value = 32'h0;
    endcase
  end

  // Read data held until the next read
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (req.rd) begin
      resp_data <= rd_value;
    end
  end

endmodule

//--- null_source.sv
module null_source (
  input  logic                          rfnoc_chdr_clk,
  input  logic                          rfnoc_chdr_rst,
  input  null_src_sink_pkg::src_cfg_t   cfg,
  input  logic [15:0]                   pkt_cnt,
  input  logic [15:0]                   line_cnt,
  output null_src_sink_pkg::pyld_beat_t pyld,
  output logic                          pyld_valid,
  input  logic                          pyld_ready,
  output null_src_sink_pkg::ctxt_beat_t ctxt,
  output logic                          ctxt_valid,
  input  logic                          ctxt_ready,
  output logic [1:0]                    state
);

  logic [11:0] lines_left;
  logic [9:0]  throttle_cntr;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      state         <= null_src_sink_pkg::st_hdr;
      lines_left    <= '0;
      throttle_cntr <= '0;
    end else begin
      case (state)
        null_src_sink_pkg::st_hdr: begin
          if (ctxt_valid && ctxt_ready) begin
            state      <= null_src_sink_pkg::st_pyld;
            lines_left <= cfg.lpp;
          end
        end
        null_src_sink_pkg::st_pyld: begin
          if (pyld_valid && pyld_ready) begin
            if (pyld.last) begin
              if (cfg.throttle == 10'd0) begin
                state <= null_src_sink_pkg::st_hdr;
              end else begin
                state         <= null_src_sink_pkg::st_wait;
                throttle_cntr <= cfg.throttle;
              end
            end else begin
              lines_left <= lines_left - 12'd1;
            end
          end
        end
        null_src_sink_pkg::st_wait: begin
          // Gap of throttle+1 idle cycles
          if (throttle_cntr == 10'd0) begin
            state <= null_src_sink_pkg::st_hdr;
          end else begin
            throttle_cntr <= throttle_cntr - 10'd1;
          end
        end
        default: begin
          state <= null_src_sink_pkg::st_hdr;
        end
      endcase
    end
  end

  // Inverted count in the upper half of each item
  assign pyld.data  = {null_src_sink_pkg::nipc{~line_cnt, line_cnt}};
  assign pyld.keep  = '1;
  assign pyld.last  = (lines_left == 12'd0);
  assign pyld_valid = (state == null_src_sink_pkg::st_pyld);

  assign ctxt.data = null_src_sink_pkg::chdr_build_header(
    6'd0, 1'b0, 1'b0, null_src_sink_pkg::chdr_pkt_type_data, 5'd0,
    pkt_cnt, cfg.bpp, 16'd0);
  assign ctxt.user  = null_src_sink_pkg::context_field_hdr;
  assign ctxt.last  = 1'b1;
  assign ctxt_valid = (state == null_src_sink_pkg::st_hdr) && cfg.en;

endmodule

//--- loop_buffer.sv
module loop_buffer #(
  parameter type beat_t = logic
) (
  input  logic  rfnoc_chdr_clk,
  input  logic  rfnoc_chdr_rst,
  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,
  output beat_t out_beat,
  output logic  out_valid,
  input  logic  out_ready
);

  beat_t skid_beat;
  logic  skid_valid;
  logic  in_fire;
  logic  out_free;

  assign in_ready = !skid_valid;
  assign in_fire  = in_valid && in_ready;
  // Output stage empty or draining this cycle
  assign out_free = !out_valid || out_ready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (out_free) begin
      out_beat <= skid_valid ? skid_beat : in_beat;
    end else if (in_fire) begin
      skid_beat <= in_beat;
    end
  end

endmodule

//--- stream_line_counter.sv
module stream_line_counter (
  input  logic                                rfnoc_chdr_clk,
  input  logic                                rfnoc_chdr_rst,
  input  logic                                clear,
  input  logic                                valid,
  input  logic                                ready,
  input  logic                                last,
  output logic [null_src_sink_pkg::cnt_w-1:0] line_cnt,
  output logic [null_src_sink_pkg::cnt_w-1:0] pkt_cnt
);

  logic accepted;

  assign accepted = valid && ready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst || clear) begin
      line_cnt <= '0;
      pkt_cnt  <= '0;
    end else if (accepted) begin
      line_cnt <= line_cnt + 1'b1;
      // End of packet
      if (last) begin
        pkt_cnt <= pkt_cnt + 1'b1;
      end
    end
  end

endmodule

//--- null_src_sink_pkg.sv
package null_src_sink_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int chdr_w = 64;
  localparam int nipc   = 2;
  localparam int item_w = 32;
  localparam int pyld_w = nipc * item_w;
  localparam int cnt_w  = 64;

  // ------------------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------------------
  localparam logic [19:0] reg_ctrl_status       = 20'h00;
  localparam logic [19:0] reg_src_lines_per_pkt = 20'h04;
  localparam logic [19:0] reg_src_bytes_per_pkt = 20'h08;
  localparam logic [19:0] reg_src_throttle_cyc  = 20'h0C;
  localparam logic [19:0] reg_snk_line_cnt_lo   = 20'h10;
  localparam logic [19:0] reg_snk_line_cnt_hi   = 20'h14;
  localparam logic [19:0] reg_snk_pkt_cnt_lo    = 20'h18;
  localparam logic [19:0] reg_snk_pkt_cnt_hi    = 20'h1C;
  localparam logic [19:0] reg_src_line_cnt_lo   = 20'h20;
  localparam logic [19:0] reg_src_line_cnt_hi   = 20'h24;
  localparam logic [19:0] reg_src_pkt_cnt_lo    = 20'h28;
  localparam logic [19:0] reg_src_pkt_cnt_hi    = 20'h2C;
  localparam logic [19:0] reg_loop_line_cnt_lo  = 20'h30;
  localparam logic [19:0] reg_loop_line_cnt_hi  = 20'h34;
  localparam logic [19:0] reg_loop_pkt_cnt_lo   = 20'h38;
  localparam logic [19:0] reg_loop_pkt_cnt_hi   = 20'h3C;

  // CHDR field values
  localparam logic [2:0] chdr_pkt_type_data = 3'd6;
  localparam logic [3:0] context_field_hdr  = 4'd0;

  // Source FSM states
  localparam logic [1:0] st_hdr  = 2'd0;
  localparam logic [1:0] st_pyld = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;

  // ------------------------------------------------------------------------
  // Beats and register port
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [pyld_w-1:0] data;
    logic [nipc-1:0]   keep;
    logic              last;
  } pyld_beat_t;

  typedef struct packed {
    logic [chdr_w-1:0] data;
    logic [3:0]        user;
    logic              last;
  } ctxt_beat_t;

  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [19:0] addr;
    logic [31:0] data;
  } ctrlport_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] data;
  } ctrlport_resp_t;

  typedef struct packed {
    logic        en;
    logic [11:0] lpp;
    logic [15:0] bpp;
    logic [9:0]  throttle;
  } src_cfg_t;

  // Header word, MSB first
  function automatic logic [chdr_w-1:0] chdr_build_header(
    input logic [5:0]  vc,
    input logic        eob,
    input logic        eov,
    input logic [2:0]  pkt_type,
    input logic [4:0]  num_mdata,
    input logic [15:0] seq_num,
    input logic [15:0] length,
    input logic [15:0] dst_epid
  );
    return {vc, eob, eov, pkt_type, num_mdata, seq_num, length, dst_epid};
  endfunction

endpackage
